/* Bender.yml */
package:
  name: nfcCopy

sources:
  - design/flashPkg.sv
  - design/copyPkg.sv
  - design/flashCycleIf.sv
  - design/copySequencer.sv
  - design/flashCycleGen.sv
  - design/nfcTop.sv
  - target: test
    files:
      - verif/flashModel.sv
      - verif/nfcChecker.sv
      - verif/nfcTb_chk.sv
      - verif/nfcTb.sv

/* design/copyPkg.sv */
package copyPkg;

    // What kind of bus cycle the generator shapes
    typedef enum logic [1:0] {
        cycCommand,  // CLE cycle
        cycAddress,  // ALE cycle
        cycCopyByte  // Read A and write B in one go
    } cycleKindE;

    // Which chips see the cycle
    typedef enum logic {
        selBoth,
        selB         // A stays quiet
    } chipSelE;

    typedef enum logic [3:0] {
        stIdle,
        stCommand,
        stColumn,
        stPageLow,
        stPageHigh,
        stWaitReadReady,
        stCopy,
        stConfirm,
        stWaitProgBusy,
        stWaitProgReady,
        stDone
    } copyStateE;

endpackage

/* design/copySequencer.sv */
`timescale 1ns/1ns

module copySequencer #(
    parameter int PageCount = 512,
    parameter int PageBytes = 512
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     rbA,
    input  logic     rbB,
    output logic     done,
    flashCycleIf.seq cyc
);
    import flashPkg::*;
    import copyPkg::*;

    localparam int PageW = (PageCount > 1) ? $clog2(PageCount) : 1;
    localparam int ByteW = (PageBytes > 1) ? $clog2(PageBytes) : 1;
    localparam logic [PageW-1:0] LastPage = PageW'(PageCount - 1);
    localparam logic [ByteW-1:0] LastByte = ByteW'(PageBytes - 1);

    copyStateE        state;
    copyStateE        stateNext;
    logic [PageW-1:0] pageCnt;
    logic [ByteW-1:0] byteCnt;
    logic [15:0]      pageAddr;  // Row address as sent in two cycles
    logic             issue;     // Request a new bus cycle this clock
    cycleKindE        kindNext;
    chipSelE          chipsNext;
    ioByteT           byteANext;
    ioByteT           byteBNext;

    assign pageAddr = 16'(pageCnt);

    // Next state and the bus cycle that goes with entering it
    always_comb begin
        stateNext = state;
        issue     = 1'b0;
        kindNext  = cycCommand;
        chipsNext = selBoth;
        byteANext = cmdRead;     // Read setup on A
        byteBNext = cmdProgram;  // Data input on B, same cycle
        case (state)
            stIdle: begin
                issue     = 1'b1;
                stateNext = stCommand;
            end
            stCommand: begin
                if (cyc.cycleDone) begin
                    issue     = 1'b1;
                    kindNext  = cycAddress;
                    byteANext = ColumnStart;
                    byteBNext = ColumnStart;
                    stateNext = stColumn;
                end
            end
            stColumn: begin
                if (cyc.cycleDone) begin
                    issue     = 1'b1;
                    kindNext  = cycAddress;
                    byteANext = pageAddr[7:0];
                    byteBNext = pageAddr[7:0];
                    stateNext = stPageLow;
                end
            end
            stPageLow: begin
                if (cyc.cycleDone) begin
                    issue     = 1'b1;
                    kindNext  = cycAddress;
                    byteANext = pageAddr[15:8];
                    byteBNext = pageAddr[15:8];
                    stateNext = stPageHigh;
                end
            end
            stPageHigh: begin
                if (cyc.cycleDone) begin
                    stateNext = stWaitReadReady;
                end
            end
            stWaitReadReady: begin
                if (rbA) begin  // A has the page in its register
                    issue     = 1'b1;
                    kindNext  = cycCopyByte;
                    stateNext = stCopy;
                end
            end
            stCopy: begin
                if (cyc.cycleDone) begin
                    issue = 1'b1;
                    if (byteCnt == LastByte) begin
                        chipsNext = selB;
                        byteBNext = cmdProgramConfirm;
                        stateNext = stConfirm;
                    end else begin
                        kindNext = cycCopyByte;
                    end
                end
            end
            stConfirm: begin
                if (cyc.cycleDone) begin
                    stateNext = stWaitProgBusy;
                end
            end
            stWaitProgBusy: begin
                if (!rbB) begin
                    stateNext = stWaitProgReady;
                end
            end
            stWaitProgReady: begin
                if (rbB) begin
                    if (pageCnt == LastPage) begin
                        stateNext = stDone;
                    end else begin
                        issue     = 1'b1;  // Next page starts with the command pair
                        stateNext = stCommand;
                    end
                end
            end
            stDone: begin
                stateNext = stDone;
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stIdle;
            pageCnt   <= '0;
            byteCnt   <= '0;
            done      <= 1'b0;
            cyc.start <= 1'b0;
        end else begin
            state     <= stateNext;
            cyc.start <= issue;
            if (state == stWaitReadReady) begin
                byteCnt <= '0;
            end else if (state == stCopy && cyc.cycleDone) begin
                byteCnt <= byteCnt + 1'b1;
            end
            if (state == stWaitProgReady && rbB && pageCnt != LastPage) begin
                pageCnt <= pageCnt + 1'b1;
            end
            if (stateNext == stDone) begin
                done <= 1'b1;  // Held until reset
            end
        end
    end

    // Request fields, valid while start is high
    always_ff @(posedge clk) begin
        if (issue) begin
            cyc.kind  <= kindNext;
            cyc.chips <= chipsNext;
            cyc.byteA <= byteANext;
            cyc.byteB <= byteBNext;
        end
    end

endmodule

/* design/flashCycleGen.sv */
`timescale 1ns/1ns

module flashCycleGen (
    input  logic            clk,
    input  logic            rst,
    flashCycleIf.gen        cyc,
    input  flashPkg::ioByteT ioAIn,
    output flashPkg::ioByteT ioAOut,
    output flashPkg::ioByteT ioBOut,
    output logic            driveA,
    output logic            driveB,
    output logic            cleA,
    output logic            aleA,
    output logic            renA,
    output logic            wenA,
    output logic            cleB,
    output logic            aleB,
    output logic            renB,
    output logic            wenB
);
    import copyPkg::*;

    logic [1:0] phase;      // 0 idle, then 1 to 3 within a cycle
    logic [1:0] phaseNext;
    logic [1:0] lastPhase;
    cycleKindE  kindQ;
    cycleKindE  kindNow;
    chipSelE    chipsQ;
    chipSelE    chipsNow;
    logic       busCle;
    logic       busAle;
    logic       busWen;

    // A new request takes effect in the same clock it arrives
    assign kindNow   = cyc.start ? cyc.kind : kindQ;
    assign chipsNow  = cyc.start ? cyc.chips : chipsQ;
    assign lastPhase = (kindQ == cycCopyByte) ? 2'd3 : 2'd2;

    always_comb begin
        if (cyc.start) begin
            phaseNext = 2'd1;
        end else if (phase == 2'd0 || phase == lastPhase) begin
            phaseNext = 2'd0;
        end else begin
            phaseNext = phase + 2'd1;
        end
    end

    assign busCle = (kindNow == cycCommand);
    assign busAle = (kindNow == cycAddress);
    assign busWen = (phaseNext == 2'd2);  // Rising WEN latches the byte

    always_ff @(posedge clk) begin
        if (rst) begin
            phase         <= 2'd0;
            cyc.cycleDone <= 1'b0;
            driveA        <= 1'b0;
            driveB        <= 1'b0;
            {cleA, aleA, renA, wenA} <= 4'b0011;
            {cleB, aleB, renB, wenB} <= 4'b0011;
        end else begin
            phase         <= phaseNext;
            cyc.cycleDone <= 1'b0;
            driveA        <= 1'b0;  // Idle unless a phase says otherwise
            driveB        <= 1'b0;
            {cleA, aleA, renA, wenA} <= 4'b0011;
            {cleB, aleB, renB, wenB} <= 4'b0011;
            if (phaseNext != 2'd0) begin
                if (kindNow == cycCopyByte) begin
                    case (phaseNext)
                        2'd1: begin
                            renA <= 1'b0;  // A drives its next byte
                        end
                        2'd2: begin
                            wenB   <= 1'b0;
                            driveB <= 1'b1;
                        end
                        default: begin
                            driveB        <= 1'b1;
                            cyc.cycleDone <= 1'b1;
                        end
                    endcase
                end else begin
                    {cleB, aleB, wenB} <= {busCle, busAle, busWen};
                    driveB             <= 1'b1;
                    if (chipsNow == selBoth) begin
                        {cleA, aleA, wenA} <= {busCle, busAle, busWen};
                        driveA             <= 1'b1;
                    end
                    cyc.cycleDone <= (phaseNext == 2'd2);
                end
            end
        end
    end

    // Latched request and data bytes
    always_ff @(posedge clk) begin
        if (cyc.start) begin
            kindQ  <= cyc.kind;
            chipsQ <= cyc.chips;
            ioAOut <= cyc.byteA;
            ioBOut <= cyc.byteB;
        end else if (phase == 2'd1 && kindQ == cycCopyByte) begin
            ioBOut <= ioAIn;  // Byte from A, held for the B write
        end
    end

endmodule

/* design/flashCycleIf.sv */
`timescale 1ns/1ns

interface flashCycleIf;
    import flashPkg::*;
    import copyPkg::*;

    logic      start;     // One clock pulse per request
    cycleKindE kind;
    chipSelE   chips;
    ioByteT    byteA;     // Byte for chip A in command and address cycles
    ioByteT    byteB;     // Byte for chip B in command and address cycles
    logic      cycleDone; // High in the last clock of the cycle

    modport seq (
        output start, kind, chips, byteA, byteB,
        input  cycleDone
    );

    modport gen (
        input  start, kind, chips, byteA, byteB,
        output cycleDone
    );

endinterface

/* design/flashPkg.sv */
package flashPkg;

    // One byte on the flash IO bus
    typedef logic [7:0] ioByteT;

    // Opcodes sent in command latch cycles
    typedef enum ioByteT {
        cmdRead           = 8'h00, // Page read setup
        cmdProgram        = 8'h80, // Serial data input
        cmdProgramConfirm = 8'h10  // Starts the page program
    } flashCmdE;

    // Every copy starts at the first byte of the page
    localparam ioByteT ColumnStart = 8'h00;

endpackage

/* design/nfcTop.sv */
`timescale 1ns/1ns

module nfcTop #(
    parameter int PageCount = 512,
    parameter int PageBytes = 512
) (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  done,
    inout  wire flashPkg::ioByteT ioA,
    output logic                  cleA,
    output logic                  aleA,
    output logic                  renA,
    output logic                  wenA,
    input  logic                  rbA,
    inout  wire flashPkg::ioByteT ioB,
    output logic                  cleB,
    output logic                  aleB,
    output logic                  renB,
    output logic                  wenB,
    input  logic                  rbB
);
    import flashPkg::*;

    ioByteT ioAOut;
    ioByteT ioBOut;
    logic   driveA;
    logic   driveB;

    flashCycleIf cycIf ();

    copySequencer #(
        .PageCount (PageCount),
        .PageBytes (PageBytes)
    ) i_copySequencer (
        .clk  (clk),
        .rst  (rst),
        .rbA  (rbA),
        .rbB  (rbB),
        .done (done),
        .cyc  (cycIf.seq)
    );

    flashCycleGen i_flashCycleGen (
        .clk    (clk),
        .rst    (rst),
        .cyc    (cycIf.gen),
        .ioAIn  (ioA),
        .ioAOut (ioAOut),
        .ioBOut (ioBOut),
        .driveA (driveA),
        .driveB (driveB),
        .cleA   (cleA),
        .aleA   (aleA),
        .renA   (renA),
        .wenA   (wenA),
        .cleB   (cleB),
        .aleB   (aleB),
        .renB   (renB),
        .wenB   (wenB)
    );

    // Pad buffers, released whenever the generator does not drive
    assign ioA = driveA ? ioAOut : 'z;
    assign ioB = driveB ? ioBOut : 'z;

endmodule

/* src.f */
design/flashPkg.sv
design/copyPkg.sv
design/flashCycleIf.sv
design/copySequencer.sv
design/flashCycleGen.sv
design/nfcTop.sv
verif/flashModel.sv
verif/nfcChecker.sv
verif/nfcTb_chk.sv
verif/nfcTb.sv

/* verif/flashModel.sv */
`timescale 1ns/1ns

module flashModel (
    input  logic      clk,
    input  logic      rst,
    inout  wire [7:0] io,
    input  logic      cle,
    input  logic      ale,
    input  logic      ren,
    input  logic      wen,
    output logic      rb,
    input  int        readBusy,  // Clocks of busy after a read setup
    input  int        progBusy   // Clocks of busy after a program confirm
);
    logic [7:0]  lastCmd;
    logic [15:0] page;     // Row address from the two page cycles
    logic [7:0]  byteIdx;
    int          addrCnt;
    int          busyCnt;
    logic        wenQ;
    logic        renQ;

    // Read data follows the content rule of chip A
    assign io = (ren === 1'b0 && !rst) ? 8'(byteIdx + 3 * page) : 'z;
    assign rb = (busyCnt == 0);

    always @(posedge clk) begin
        wenQ <= wen;
        renQ <= ren;
        if (rst) begin
            busyCnt <= 0;
            addrCnt <= 0;
            byteIdx <= '0;
            page    <= '0;
            lastCmd <= 8'hff;
        end else begin
            if (busyCnt > 0) begin
                busyCnt <= busyCnt - 1;
            end
            if (wen && !wenQ) begin  // Rising write strobe latches the bus
                if (cle) begin
                    lastCmd <= io;
                    addrCnt <= 0;
                    if (io == 8'h10) begin
                        busyCnt <= progBusy;  // Array program
                    end
                end else if (ale) begin
                    addrCnt <= addrCnt + 1;
                    if (addrCnt == 1) begin
                        page[7:0] <= io;
                    end
                    if (addrCnt == 2) begin
                        page[15:8] <= io;
                        byteIdx    <= '0;
                        if (lastCmd == 8'h00) begin
                            busyCnt <= readBusy;  // Page load into the register
                        end
                    end
                end
            end
            if (ren && !renQ) begin
                byteIdx <= byteIdx + 1'b1;  // Next byte after each read
            end
        end
    end

endmodule

/* verif/nfcChecker.sv */
`timescale 1ns/1ns

module nfcChecker #(
    parameter int PageCount = 4,
    parameter int PageBytes = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       done,
    input  logic [7:0] ioA,
    input  logic [7:0] ioB,
    input  logic       cleA,
    input  logic       aleA,
    input  logic       renA,
    input  logic       wenA,
    input  logic       cleB,
    input  logic       aleB,
    input  logic       renB,
    input  logic       wenB,
    input  logic       rbB,
    input  int         expPages,
    output int         errors
);
    logic [7:0] strobes;
    logic [7:0] strobesQ;
    logic       wenAQ;
    logic       wenBQ;
    logic       doneQ;
    logic       rstQ  = 1'b0;
    logic       rstQ2 = 1'b0;
    int         aStep;
    int         bStep;
    int         page;      // Page that the next program belongs to

    assign strobes = {cleA, aleA, renA, wenA, cleB, aleB, renB, wenB};

    initial errors = 0;

    function automatic logic [7:0] pageByte(int pg, int idx);
        return 8'((idx + 3 * pg) % 256);
    endfunction

    task automatic mismatch(string name, logic [15:0] expVal, logic [15:0] actVal);
        errors++;
        $display("FAILED t=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
    endtask

    task automatic problem(string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    // Expected latch kind is {CLE, ALE}
    task automatic checkCycle(string chip, int step, logic [1:0] kind, logic [7:0] data);
        logic [1:0] expKind;
        logic [7:0] expVal;
        expKind = 2'b01;
        case (step)
            0: begin
                expKind = 2'b10;
                expVal  = (chip == "B") ? 8'h80 : 8'h00;
            end
            1: expVal = 8'h00;
            2: expVal = 8'(page % 256);
            3: expVal = 8'(page / 256);
            default: begin
                expKind = (step < 4 + PageBytes) ? 2'b00 : 2'b10;
                expVal  = (step < 4 + PageBytes) ? pageByte(page, step - 4) : 8'h10;
            end
        endcase
        if (kind !== expKind) mismatch({"cle", chip, "/ale", chip}, expKind, kind);
        if (data !== expVal) mismatch({"io", chip}, expVal, data);
    endtask

    always @(posedge clk) begin
        rstQ     <= rst;
        rstQ2    <= rstQ;
        wenAQ    <= wenA;
        wenBQ    <= wenB;
        doneQ    <= done;
        strobesQ <= strobes;
        if (rstQ || rstQ2) begin  // In reset and one clock past it
            if ({strobes, done} !== 9'b0011_0011_0) mismatch("strobes/done", 9'h066, {strobes, done});
            if (ioA !== 8'hff) mismatch("ioA", 8'hff, ioA);
            if (ioB !== 8'hff) mismatch("ioB", 8'hff, ioB);
        end
        if (rst) begin
            aStep = 0;
            bStep = 0;
            page  = 0;
        end else begin
            if (wenA && !wenAQ) begin
                checkCycle("A", aStep, {cleA, aleA}, ioA);
                aStep = (aStep + 1) % 4;
            end
            if (wenB && !wenBQ) begin
                if (page >= PageCount) problem("chip B written after the last page");
                checkCycle("B", bStep, {cleB, aleB}, ioB);
                bStep = (bStep + 1) % (5 + PageBytes);
                page  = (bStep == 0) ? page + 1 : page;
            end
            if (done && !doneQ) begin
                if (page != expPages) mismatch("programmed pages", expPages, page);
                if (rbB !== 1'b1) problem("done rose while chip B was still busy");
            end
            if (done && doneQ && strobes !== strobesQ) problem("a strobe toggled after done");
        end
    end

endmodule

/* verif/nfcTb.sv */
`timescale 1ns/1ns

module nfcTb;
    localparam int PageCount = 4;
    localparam int PageBytes = 8;
    localparam int NumRows   = 4;
    localparam int WaitLimit = 5000;  // Clocks allowed for one copy run

    // Stimulus table, one array per column
    // Busy times in clocks with -1 for a random time, resetAt 0 for no mid-run reset
    string nameTab     [NumRows] = '{"short busy", "long busy", "random busy", "mid-run reset"};
    int    readBusyTab [NumRows] = '{1, 40, -1, 5};
    int    progBusyTab [NumRows] = '{1, 60, -1, 8};
    int    resetAtTab  [NumRows] = '{0, 0, 0, 150};
    int    expPagesTab [NumRows] = '{PageCount, PageCount, PageCount, PageCount};

    logic      clk;
    logic      rst;
    logic      done;
    tri1 [7:0] ioA;  // Pull-ups on both buses
    tri1 [7:0] ioB;
    logic      cleA, aleA, renA, wenA, rbA;
    logic      cleB, aleB, renB, wenB, rbB;
    int        readBusy;
    int        progBusy;
    int        expPages;
    int        checkErrors;
    int        failedTests;
    int        errBefore;
    int        rowErrors;
    int        r;
    bit        timedOut;

    nfcTop #(
        .PageCount (PageCount),
        .PageBytes (PageBytes)
    ) i_nfcTop (
        .clk (clk), .rst (rst), .done (done),
        .ioA (ioA), .cleA (cleA), .aleA (aleA), .renA (renA), .wenA (wenA), .rbA (rbA),
        .ioB (ioB), .cleB (cleB), .aleB (aleB), .renB (renB), .wenB (wenB), .rbB (rbB)
    );

    flashModel i_flashA (
        .clk (clk), .rst (rst), .io (ioA), .cle (cleA), .ale (aleA), .ren (renA),
        .wen (wenA), .rb (rbA), .readBusy (readBusy), .progBusy (progBusy)
    );

    flashModel i_flashB (
        .clk (clk), .rst (rst), .io (ioB), .cle (cleB), .ale (aleB), .ren (renB),
        .wen (wenB), .rb (rbB), .readBusy (readBusy), .progBusy (progBusy)
    );

    nfcChecker #(
        .PageCount (PageCount),
        .PageBytes (PageBytes)
    ) i_checker (
        .clk (clk), .rst (rst), .done (done), .ioA (ioA), .ioB (ioB),
        .cleA (cleA), .aleA (aleA), .renA (renA), .wenA (wenA),
        .cleB (cleB), .aleB (aleB), .renB (renB), .wenB (wenB), .rbB (rbB),
        .expPages (expPages), .errors (checkErrors)
    );

    bind nfcTop nfcTb_chk i_chk (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int errorTotal();
        return checkErrors + i_nfcTop.i_chk.assertFails;
    endfunction

    task automatic resetDut();
        @(posedge clk);
        #5;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    task automatic waitForDone(input int resetAt, output bit timeout);
        int cycles;
        cycles = 0;
        while (done !== 1'b1 && cycles < WaitLimit) begin
            @(posedge clk);
            #5;
            cycles++;
            if (cycles == resetAt) resetDut();  // Restart in the middle of the copy
        end
        timeout = (done !== 1'b1);
    endtask

    initial begin
        void'($urandom(32'he0d1));
        rst         = 1'b1;
        readBusy    = 1;
        progBusy    = 1;
        expPages    = PageCount;
        failedTests = 0;
        timedOut    = 1'b0;
        r           = 0;
        while (r < NumRows && !timedOut) begin
            @(posedge clk);
            #5;
            readBusy  = (readBusyTab[r] < 0) ? 1 + $urandom % 50 : readBusyTab[r];
            progBusy  = (progBusyTab[r] < 0) ? 1 + $urandom % 50 : progBusyTab[r];
            expPages  = expPagesTab[r];
            errBefore = errorTotal();
            resetDut();
            waitForDone(resetAtTab[r], timedOut);
            if (timedOut) begin
                failedTests++;
                $display("Test %0d %s: done did not rise within %0d clocks",
                         r, nameTab[r], WaitLimit);
            end else begin
                repeat (20) @(posedge clk);  // Bus must stay quiet once done
                rowErrors = errorTotal() - errBefore;
                if (rowErrors != 0) failedTests++;
                $display("Test %0d %s: %s, busy %0d/%0d, %0d errors", r, nameTab[r],
                         (rowErrors == 0) ? "ok" : "wrong", readBusy, progBusy, rowErrors);
            end
            r++;
        end
        $display("Tests run: %0d, failed: %0d, check errors: %0d", r, failedTests, errorTotal());
        if (failedTests == 0 && !timedOut && errorTotal() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* verif/nfcTb_chk.sv */
`timescale 1ns/1ns

module nfcTb_chk (
    input logic clk,
    input logic rst,
    input logic done,
    input logic cleA,
    input logic aleA,
    input logic renA,
    input logic wenA,
    input logic cleB,
    input logic aleB,
    input logic renB,
    input logic wenB,
    input logic rbA
);
    int assertFails = 0;

    cleAleExclusive: assert property (@(posedge clk) disable iff (rst)
        !(cleA && aleA) && !(cleB && aleB))
        else begin
            assertFails++;
            $error("CLE and ALE high together");
        end

    wenRenExclusive: assert property (@(posedge clk) disable iff (rst)
        (wenA || renA) && (wenB || renB))
        else begin
            assertFails++;
            $error("WEN and REN low together");
        end

    // No read from A before its page register is loaded
    readWhileBusy: assert property (@(posedge clk) disable iff (rst) renA || rbA)
        else begin
            assertFails++;
            $error("REN on chip A low while chip A busy");
        end

    doneHeld: assert property (@(posedge clk) disable iff (rst) done |=> done)
        else begin
            assertFails++;
            $error("done fell without reset");
        end

endmodule
